//--- tb.f
hdl/btb_pkg.sv
hdl/btb_bank.sv
hdl/btb_window_align.sv
hdl/btb_mem.sv
tb/tb_clkgen.sv
tb/btb_mem_checker.sv
tb/btb_mem_tb.sv

//--- Makefile
# verilator build and run of the btb testbench
TOP := btb_mem_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -Mdir obj_dir

# fails on a nonzero exit or on the fail message in the log
run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TEST FAIL" sim.log; then \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- tb/btb_mem_tb.sv
//------------------------------
// btb testbench: lfsr stimulus, reference model,
// directed and random tests, watchdog and report
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module btb_mem_tb;
   import btb_pkg::*;

   localparam logic [31:0] SEED = 32'hd96f_1092;
   localparam int LINES      = 1 << INDEX_W;
   localparam int N_WRITES   = 48;
   localparam int N_RANDOM   = 400;
   // one 20 ns cycle per operation, 64 covers the directed tests
   localparam int TOTAL_OPS  = 3 * 64 + N_WRITES + N_RANDOM;
   localparam int TIMEOUT_NS = TOTAL_OPS * 40 + 1000;

   logic        clk;
   logic        rst;
   btb_rd_req_t rd_req;
   btb_wr_req_t wr_req;
   btb_rd_rsp_t rd_rsp;

   // reference state
   btb_entry_t       model [LINES][WAYS];
   logic [TAG_W-1:0] line_tag [LINES];
   btb_rd_rsp_t      pending [$];
   logic [31:0]      lfsr_state = SEED;

   string cur_test;
   int    checks;
   int    errors;
   int    tests;
   int    test_checks;
   int    test_errors;

   tb_clkgen u_clkgen (
      .clk (clk),
      .rst (rst)
   );

   btb_mem btb_mem_inst (
      .clk    (clk),
      .rst    (rst),
      .rd_req (rd_req),
      .wr_req (wr_req),
      .rd_rsp (rd_rsp)
   );

   //------------------------------
   // random numbers
   //------------------------------

   // taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one lfsr step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   //------------------------------
   // request builders
   //------------------------------

   function automatic btb_entry_t make_entry(input logic [TAG_W-1:0] tag,
                                             input logic [SLOT_W-1:0] slot,
                                             input logic [TGT_W-1:0] target);
      btb_entry_t e;
      e.valid  = 1'b1;
      e.tag    = tag;
      e.slot   = slot;
      e.target = target;
      return e;
   endfunction

   // mostly the line's own tag so that reads hit
   function automatic btb_entry_t random_entry(input logic [INDEX_W-1:0] idx);
      btb_entry_t e;
      e.valid  = (rand_bits(3) != 0);
      e.tag    = (rand_bits(2) != 0) ? line_tag[idx] : TAG_W'(rand_bits(TAG_W));
      e.slot   = SLOT_W'(rand_bits(SLOT_W));
      e.target = TGT_W'(rand_bits(TGT_W));
      return e;
   endfunction

   function automatic btb_rd_req_t make_rd(input logic [INDEX_W-1:0] idx,
                                           input logic [SLOT_W-1:0] start);
      btb_rd_req_t r;
      logic [INDEX_W-1:0] nxt;
      nxt      = idx + INDEX_W'(1);
      r.valid  = 1'b1;
      r.index  = idx;
      r.tag    = line_tag[idx];
      r.tag_p1 = line_tag[nxt];
      r.start  = start;
      return r;
   endfunction

   function automatic btb_wr_req_t make_wr(input logic [INDEX_W-1:0] idx, input logic way,
                                           input btb_entry_t e);
      btb_wr_req_t w;
      w.valid = 1'b1;
      w.index = idx;
      w.way   = way;
      w.entry = e;
      return w;
   endfunction

   //------------------------------
   // reference model
   //------------------------------

   // {hit, target} of one slot, way 0 scanned first
   function automatic logic [TGT_W:0] lookup(input logic [INDEX_W-1:0] idx,
                                             input logic [TAG_W-1:0] tag,
                                             input logic [SLOT_W-1:0] slot);
      for (int w = 0; w < WAYS; w++) begin
         if (model[idx][w].valid && model[idx][w].tag == tag && model[idx][w].slot == slot) begin
            return {1'b1, model[idx][w].target};
         end
      end
      return '0;
   endfunction

   // start 1 takes window slot 1 from slot 0 of the next line
   function automatic btb_rd_rsp_t expect_rsp(input btb_rd_req_t r);
      btb_rd_rsp_t e;
      logic [TGT_W:0] s0;
      logic [TGT_W:0] s1;
      if (r.start == 1'b0) begin
         s0 = lookup(r.index, r.tag, 1'b0);
         s1 = lookup(r.index, r.tag, 1'b1);
      end else begin
         s0 = lookup(r.index, r.tag, 1'b1);
         s1 = lookup(r.index + INDEX_W'(1), r.tag_p1, 1'b0);
      end
      e.valid     = 1'b1;
      e.hit       = {s1[TGT_W], s0[TGT_W]};
      e.target[0] = s0[TGT_W-1:0];
      e.target[1] = s1[TGT_W-1:0];
      return e;
   endfunction

   // storage of the bank that owns the line, valid from the valid bits
   function automatic btb_entry_t stored_entry(input logic [INDEX_W-1:0] idx, input logic way);
      btb_entry_t e;
      if (idx[0]) begin
         e       = btb_mem_inst.u_bank_odd.mem[idx[INDEX_W-1:1]][way];
         e.valid = btb_mem_inst.u_bank_odd.vld[idx[INDEX_W-1:1]][way];
      end else begin
         e       = btb_mem_inst.u_bank_even.mem[idx[INDEX_W-1:1]][way];
         e.valid = btb_mem_inst.u_bank_even.vld[idx[INDEX_W-1:1]][way];
      end
      return e;
   endfunction

   //------------------------------
   // compare and drive
   //------------------------------

   task automatic compare_rsp(input btb_rd_rsp_t expected, input btb_rd_rsp_t actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAIL %s: expected %h actual %h", cur_test, expected, actual);
      end
   endtask

   task automatic compare_entry(input btb_entry_t expected, input btb_entry_t actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAIL %s: expected %h actual %h", cur_test, expected, actual);
      end
   endtask

   // sampled mid-cycle, one cycle after the strobe
   task automatic check_response();
      btb_rd_rsp_t expected;
      if (rd_rsp.valid) begin
         if (pending.size() == 0) begin
            errors++;
            $display("test %s: read response arrived with no read pending", cur_test);
         end else begin
            expected = pending.pop_front();
            compare_rsp(expected, rd_rsp);
         end
      end else if (pending.size() != 0) begin
         errors++;
         $display("test %s: no read response one cycle after the request", cur_test);
         pending.delete();
      end
   endtask

   // one cycle, called on a falling edge
   // the model takes the write after the read expectation is fixed
   task automatic step(input btb_rd_req_t rd, input btb_wr_req_t wr, input btb_rd_rsp_t exp);
      check_response();
      rd_req = rd;
      wr_req = wr;
      if (rd.valid) begin
         pending.push_back(exp);
      end
      if (wr.valid) begin
         model[wr.index][wr.way] = wr.entry;
      end
      @(negedge clk);
   endtask

   task automatic read_line(input logic [INDEX_W-1:0] idx, input logic [SLOT_W-1:0] start);
      btb_rd_req_t r;
      r = make_rd(idx, start);
      step(r, '0, expect_rsp(r));
   endtask

   task automatic write_entry(input logic [INDEX_W-1:0] idx, input logic way,
                              input btb_entry_t e);
      step('0, make_wr(idx, way, e), '0);
   endtask

   task automatic begin_test(input string name);
      cur_test    = name;
      test_checks = checks;
      test_errors = errors;
   endtask

   // one idle cycle drains the last response
   task automatic end_test();
      step('0, '0, '0);
      tests++;
      $display("test %s: %0d checks, %0d errors", cur_test,
               checks - test_checks, errors - test_errors);
   endtask

   //------------------------------
   // tests
   //------------------------------

   task automatic after_reset_reads();
      btb_rd_rsp_t zero;
      zero = '0;
      begin_test("after_reset");
      compare_rsp(zero, rd_rsp);
      for (int i = 0; i < LINES; i++) begin
         for (int s = 0; s < SLOTS; s++) begin
            read_line(INDEX_W'(i), SLOT_W'(s));
         end
      end
      end_test();
   endtask

   task automatic write_then_read();
      logic [INDEX_W-1:0] idx;
      btb_entry_t e;
      begin_test("write_then_read");
      for (int n = 0; n < N_WRITES; n++) begin
         idx     = INDEX_W'(rand_bits(INDEX_W));
         e       = random_entry(idx);
         e.valid = 1'b1;
         write_entry(idx, 1'(rand_bits(1)), e);
      end
      // storage readback of every valid way
      for (int i = 0; i < LINES; i++) begin
         for (int w = 0; w < WAYS; w++) begin
            if (model[i][w].valid) begin
               compare_entry(model[i][w], stored_entry(INDEX_W'(i), 1'(w)));
            end
         end
      end
      for (int i = 0; i < LINES; i++) begin
         for (int s = 0; s < SLOTS; s++) begin
            read_line(INDEX_W'(i), SLOT_W'(s));
         end
      end
      end_test();
   endtask

   task automatic wrap_and_bank_order();
      btb_rd_req_t r_even;
      btb_rd_req_t r_odd;
      btb_entry_t  e;
      begin_test("wrap_bank_order");
      // 31 start 1 takes slot 0 of line 0
      write_entry(0, 1'b0, make_entry(line_tag[0], 1'b0, TGT_W'(rand_bits(TGT_W))));
      write_entry(31, 1'b0, make_entry(line_tag[31], 1'b1, TGT_W'(rand_bits(TGT_W))));
      read_line(31, 1'b1);
      read_line(31, 1'b0);
      // lines 10,11 mirrored into 21,22, fetch line even then odd
      line_tag[21] = line_tag[10];
      line_tag[22] = line_tag[11];
      for (int w = 0; w < WAYS; w++) begin
         e       = random_entry(10);
         e.valid = 1'b1;
         write_entry(10, 1'(w), e);
         write_entry(21, 1'(w), e);
         e       = random_entry(11);
         e.valid = 1'b1;
         write_entry(11, 1'(w), e);
         write_entry(22, 1'(w), e);
      end
      for (int s = 0; s < SLOTS; s++) begin
         r_even = make_rd(10, SLOT_W'(s));
         r_odd  = make_rd(21, SLOT_W'(s));
         step(r_even, '0, expect_rsp(r_even));
         step(r_odd, '0, expect_rsp(r_even));
      end
      end_test();
   endtask

   task automatic tag_mismatch_invalidate();
      btb_rd_req_t r;
      begin_test("tag_invalidate");
      write_entry(6, 1'b0, make_entry(line_tag[6], 1'b0, TGT_W'(rand_bits(TGT_W))));
      write_entry(6, 1'b1, '0);
      r     = make_rd(6, 1'b0);
      r.tag = ~r.tag;
      step(r, '0, expect_rsp(r));
      // same edge as the invalidate still sees the old hit
      r = make_rd(6, 1'b0);
      step(r, make_wr(6, 1'b0, '0), expect_rsp(r));
      step(r, '0, expect_rsp(r));
      end_test();
   endtask

   task automatic way_priority();
      begin_test("way_priority");
      write_entry(12, 1'b1, make_entry(line_tag[12], 1'b1, TGT_W'(rand_bits(TGT_W))));
      write_entry(12, 1'b0, make_entry(line_tag[12], 1'b1, TGT_W'(rand_bits(TGT_W))));
      read_line(12, 1'b0);
      read_line(12, 1'b1);
      end_test();
   endtask

   // a read every cycle, a write about every other cycle
   task automatic random_traffic();
      btb_rd_req_t r;
      btb_wr_req_t w;
      logic [INDEX_W-1:0] widx;
      begin_test("random_traffic");
      for (int n = 0; n < N_RANDOM; n++) begin
         r = make_rd(INDEX_W'(rand_bits(INDEX_W)), SLOT_W'(rand_bits(SLOT_W)));
         if (rand_bits(3) == 0) begin
            r.tag = TAG_W'(rand_bits(TAG_W));
         end
         w = '0;
         if (rand_bits(1) != 0) begin
            widx = INDEX_W'(rand_bits(INDEX_W));
            w    = make_wr(widx, 1'(rand_bits(1)), random_entry(widx));
         end
         step(r, w, expect_rsp(r));
      end
      end_test();
   endtask

   //------------------------------
   // main sequence and watchdog
   //------------------------------

   initial begin
      rd_req = '0;
      wr_req = '0;
      for (int i = 0; i < LINES; i++) begin
         line_tag[i] = TAG_W'(rand_bits(TAG_W));
         for (int w = 0; w < WAYS; w++) begin
            model[i][w] = '0;
         end
      end
      // reset is seen low at a rising edge, stimulus starts on the next falling edge
      @(negedge clk);
      while (rst) begin
         @(posedge clk);
      end
      @(negedge clk);
      after_reset_reads();
      write_then_read();
      wrap_and_bank_order();
      tag_mismatch_invalidate();
      way_priority();
      random_traffic();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("timeout: tests did not finish within %0d ns", TIMEOUT_NS);
      $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb/btb_mem_checker.sv
//------------------------------
// btb response timing and reset assertions, bound to btb_mem
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module btb_mem_checker (
   input logic                 clk,
   input logic                 rst,
   input btb_pkg::btb_rd_req_t rd_req,
   input btb_pkg::btb_rd_rsp_t rd_rsp
);

   // every read strobe is answered in the next cycle
   rsp_follows_req: assert property (
      @(posedge clk) disable iff (rst)
      rd_req.valid |=> rd_rsp.valid
   ) else $error("no read response in the cycle after a read request");

   // a response only ever comes right after a strobe
   no_rsp_without_req: assert property (
      @(posedge clk)
      rd_rsp.valid |-> $past(rd_req.valid)
   ) else $error("read response valid without a read request one cycle before");

   // hits stay quiet outside response cycles and in reset
   no_hit_when_idle: assert property (
      @(posedge clk)
      (rst || !rd_rsp.valid) |-> (rd_rsp.hit == '0)
   ) else $error("hit set while response valid is low or reset is high");

endmodule

bind btb_mem btb_mem_checker u_checker (
   .clk    (clk),
   .rst    (rst),
   .rd_req (rd_req),
   .rd_rsp (rd_rsp)
);

`default_nettype wire

//--- tb/tb_clkgen.sv
//------------------------------
// testbench clock and reset
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
   output logic clk,
   output logic rst
);
   // 20 ns period
   localparam int HALF_NS = 10;

   initial begin
      clk = 1'b0;
      forever #(HALF_NS) clk = ~clk;
   end

   // two rising edges in reset, released on a falling edge
   initial begin
      rst = 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

`default_nettype wire

//--- hdl/btb_mem.sv
//------------------------------
// btb top: even bank, odd bank and window aligner
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module btb_mem (
   input  logic                 clk,
   input  logic                 rst,
   input  btb_pkg::btb_rd_req_t rd_req,
   input  btb_pkg::btb_wr_req_t wr_req,
   output btb_pkg::btb_rd_rsp_t rd_rsp
);
   import btb_pkg::*;

   // registered per-bank results
   btb_line_rsp_t bank_even_rsp;
   btb_line_rsp_t bank_odd_rsp;

   //------------------------------
   // banks
   //------------------------------

   // even index lines
   btb_bank #(
      .PARITY (0)
   ) u_bank_even (
      .clk      (clk),
      .rst      (rst),
      .rd_req   (rd_req),
      .wr_req   (wr_req),
      .line_rsp (bank_even_rsp)
   );

   // odd index lines
   btb_bank #(
      .PARITY (1)
   ) u_bank_odd (
      .clk      (clk),
      .rst      (rst),
      .rd_req   (rd_req),
      .wr_req   (wr_req),
      .line_rsp (bank_odd_rsp)
   );

   //------------------------------
   // window align
   //------------------------------

   // combinational, same cycle as the bank registers
   btb_window_align u_align (
      .bank_even_rsp (bank_even_rsp),
      .bank_odd_rsp  (bank_odd_rsp),
      .rd_rsp        (rd_rsp)
   );

endmodule

`default_nettype wire

//--- hdl/btb_window_align.sv
//------------------------------
// btb window align: line ordering and slot window select
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module btb_window_align (
   input  btb_pkg::btb_line_rsp_t bank_even_rsp,
   input  btb_pkg::btb_line_rsp_t bank_odd_rsp,
   output btb_pkg::btb_rd_rsp_t   rd_rsp
);
   import btb_pkg::*;

   // fetch line and next line after reordering
   btb_line_rsp_t                   line0;
   btb_line_rsp_t                   line1;

   // both lines laid end to end, fetch line in the low slots
   logic [2*SLOTS-1:0]              hit_cat;
   logic [2*SLOTS-1:0][TGT_W-1:0]   tgt_cat;

   // position of each window slot in the concatenation
   logic [SLOTS-1:0][SLOT_W:0]      sel;

   //------------------------------
   // line order
   //------------------------------

   // banks are even/odd, the fetch line can sit in either
   // even bank first flag decides the order
   assign line0 = bank_even_rsp.first ? bank_even_rsp : bank_odd_rsp;
   assign line1 = bank_even_rsp.first ? bank_odd_rsp  : bank_even_rsp;

   assign hit_cat = {line1.hit, line0.hit};
   assign tgt_cat = {line1.target, line0.target};

   //------------------------------
   // window
   //------------------------------

   // start 0 -> L0 s0, L0 s1
   // start 1 -> L0 s1, L1 s0
   always_comb begin
      for (int s = 0; s < SLOTS; s++) begin
         sel[s] = {1'b0, line0.start} + (SLOT_W + 1)'(s);
      end
   end

   // misses show a zero target
   always_comb begin
      for (int s = 0; s < SLOTS; s++) begin
         rd_rsp.hit[s] = hit_cat[sel[s]];
         if (hit_cat[sel[s]]) begin
            rd_rsp.target[s] = tgt_cat[sel[s]];
         end else begin
            rd_rsp.target[s] = '0;
         end
      end
   end

   // both banks register the same strobe
   assign rd_rsp.valid = line0.valid & line1.valid;

endmodule

`default_nettype wire

//--- hdl/btb_bank.sv
//------------------------------
// one btb bank: entry storage, valid bits,
// read register, tag compare and per-slot hit
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module btb_bank #(
   parameter int PARITY = 0
) (
   input  logic                   clk,
   input  logic                   rst,
   input  btb_pkg::btb_rd_req_t   rd_req,
   input  btb_pkg::btb_wr_req_t   wr_req,
   output btb_pkg::btb_line_rsp_t line_rsp
);
   import btb_pkg::*;

   // index bit 0 picks the bank, the rest picks the row
   localparam int   ROW_W    = INDEX_W - 1;
   localparam int   ROWS     = 1 << ROW_W;
   localparam logic BANK_BIT = 1'(PARITY);

   // entry payload, written only when validating
   btb_entry_t                    mem [ROWS][WAYS];
   // valid bits, cleared by reset
   logic [ROWS-1:0][WAYS-1:0]     vld;

   // read address side
   logic                          fetch_here;
   logic [INDEX_W-1:0]            next_index;
   logic [INDEX_W-1:0]            rd_index;
   logic [ROW_W-1:0]              rd_row;
   logic [TAG_W-1:0]              rd_tag;
   btb_entry_t                    rd_way [WAYS];

   // read register stage
   logic                          rsp_valid_q;
   logic                          first_q;
   logic [SLOT_W-1:0]             start_q;
   logic [TAG_W-1:0]              tag_q;
   btb_entry_t                    way_q [WAYS];

   // compare stage
   logic [WAYS-1:0][SLOTS-1:0]    match;
   logic [SLOTS-1:0]              hit;
   logic [SLOTS-1:0][TGT_W-1:0]   target;

   // write side
   logic                          wr_here;
   logic [ROW_W-1:0]              wr_row;

   //------------------------------
   // write
   //------------------------------

   // only writes whose low index bit matches this bank
   assign wr_here = wr_req.valid && (wr_req.index[0] == BANK_BIT);
   assign wr_row  = wr_req.index[INDEX_W-1:1];

   // payload only moves on a validating write
   // an invalidate leaves the old data behind the cleared valid bit
   always_ff @(posedge clk) begin
      if (wr_here && wr_req.entry.valid) begin
         mem[wr_row][wr_req.way] <= wr_req.entry;
      end
   end

   // valid follows the entry valid of every write to this bank
   always_ff @(posedge clk) begin
      if (rst) begin
         vld <= '0;
      end else if (wr_here) begin
         vld[wr_row][wr_req.way] <= wr_req.entry.valid;
      end
   end

   //------------------------------
   // read address
   //------------------------------

   // fetch line lives here when its low bit is ours
   assign fetch_here = (rd_req.index[0] == BANK_BIT);

   // next line, 31 wraps to 0
   assign next_index = rd_req.index + INDEX_W'(1);

   // otherwise this bank serves the next line
   // whose low bit is ours by construction
   assign rd_index = fetch_here ? rd_req.index : next_index;
   assign rd_row   = rd_index[INDEX_W-1:1];

   // tag that goes with the line this bank serves
   assign rd_tag = fetch_here ? rd_req.tag : rd_req.tag_p1;

   // both ways of the row, valid taken from the valid bits
   always_comb begin
      for (int w = 0; w < WAYS; w++) begin
         rd_way[w]       = mem[rd_row][w];
         rd_way[w].valid = vld[rd_row][w];
      end
   end

   //------------------------------
   // read register
   //------------------------------

   // response valid one cycle after the strobe
   always_ff @(posedge clk) begin
      if (rst) begin
         rsp_valid_q <= 1'b0;
      end else begin
         rsp_valid_q <= rd_req.valid;
      end
   end

   // line order and window start for the aligner
   always_ff @(posedge clk) begin
      if (rst) begin
         first_q <= 1'b0;
         start_q <= '0;
      end else if (rd_req.valid) begin
         first_q <= fetch_here;
         start_q <= rd_req.start;
      end
   end

   // sampled before any write at the same edge lands
   always_ff @(posedge clk) begin
      if (rd_req.valid) begin
         tag_q <= rd_tag;
         for (int w = 0; w < WAYS; w++) begin
            way_q[w] <= rd_way[w];
         end
      end
   end

   //------------------------------
   // tag compare and way select
   //------------------------------

   // way hits a slot on valid, tag and slot number
   always_comb begin
      for (int w = 0; w < WAYS; w++) begin
         for (int s = 0; s < SLOTS; s++) begin
            match[w][s] = way_q[w].valid &&
                          (way_q[w].tag == tag_q) &&
                          (way_q[w].slot == SLOT_W'(s));
         end
      end
   end

   // scan from the top way down so way 0 wins
   // target of a miss is don't care, zeroed in the aligner
   always_comb begin
      for (int s = 0; s < SLOTS; s++) begin
         hit[s]    = 1'b0;
         target[s] = way_q[0].target;
         for (int w = WAYS - 1; w >= 0; w--) begin
            if (match[w][s]) begin
               hit[s]    = 1'b1;
               target[s] = way_q[w].target;
            end
         end
         // no hit outside a response cycle
         hit[s] = hit[s] & rsp_valid_q;
      end
   end

   //------------------------------
   // line response
   //------------------------------

   assign line_rsp.valid  = rsp_valid_q;
   assign line_rsp.first  = first_q;
   assign line_rsp.start  = start_q;
   assign line_rsp.hit    = hit;
   assign line_rsp.target = target;

endmodule

`default_nettype wire

//--- hdl/btb_pkg.sv
//------------------------------
// btb widths, entry struct, read/write request structs
// and the per-line and window response structs
//------------------------------
`default_nettype none

package btb_pkg;

   //------------------------------
   // geometry
   //------------------------------

   // 32 fetch lines, split even/odd across two banks
   localparam int INDEX_W = 5;
   // tag compared against the stored entry
   localparam int TAG_W   = 9;
   // branch target payload
   localparam int TGT_W   = 20;
   // branch slots per line
   localparam int SLOTS   = 2;
   localparam int SLOT_W  = 1;
   // set associativity
   localparam int WAYS    = 2;

   //------------------------------
   // stored entry
   //------------------------------

   // one way of one line
   typedef struct packed {
      logic              valid;
      logic [TAG_W-1:0]  tag;
      // slot within the line that holds the branch
      logic [SLOT_W-1:0] slot;
      logic [TGT_W-1:0]  target;
   } btb_entry_t;

   //------------------------------
   // requests
   //------------------------------

   // read strobe, looks up the fetch line and the line after it
   typedef struct packed {
      logic               valid;
      logic [INDEX_W-1:0] index;
      // tag of the fetch line
      logic [TAG_W-1:0]   tag;
      // tag of index plus one
      logic [TAG_W-1:0]   tag_p1;
      // first slot of the window in the fetch line
      logic [SLOT_W-1:0]  start;
   } btb_rd_req_t;

   // write strobe, replaces one way of one line
   // clear entry.valid to invalidate that way
   typedef struct packed {
      logic                     valid;
      logic [INDEX_W-1:0]       index;
      logic [$clog2(WAYS)-1:0]  way;
      btb_entry_t               entry;
   } btb_wr_req_t;

   //------------------------------
   // responses
   //------------------------------

   // result of one bank, already resolved per slot
   typedef struct packed {
      logic                        valid;
      // bank held the fetch line, not the next line
      logic                        first;
      logic [SLOT_W-1:0]           start;
      logic [SLOTS-1:0]            hit;
      logic [SLOTS-1:0][TGT_W-1:0] target;
   } btb_line_rsp_t;

   // window of slots starting at the fetch start
   typedef struct packed {
      logic                        valid;
      logic [SLOTS-1:0]            hit;
      logic [SLOTS-1:0][TGT_W-1:0] target;
   } btb_rd_rsp_t;

endpackage

`default_nettype wire
